// ==== hdl/fmul_mant_mult.sv ====
`default_nettype none
`timescale 1ns/100ps

module fmul_mant_mult (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          s1_valid,
   input  logic                          s1_sign,
   input  logic [fmul_pkg::mant_w-1:0]   s1_mant_a,
   input  logic [fmul_pkg::mant_w-1:0]   s1_mant_b,
   input  logic [fmul_pkg::exp_w-1:0]    s1_exp_a,
   input  logic [fmul_pkg::exp_w-1:0]    s1_exp_b,
   input  fmul_pkg::spec_t               s1_class,
   input  logic [fmul_pkg::word_w-1:0]   s1_payload,
   output logic                          s2_valid,
   output logic                          s2_sign,
   output logic [fmul_pkg::prod_w-1:0]   s2_prod,
   output logic [fmul_pkg::expi_w-1:0]   s2_exp_sum,
   output fmul_pkg::spec_t               s2_class,
   output logic [fmul_pkg::word_w-1:0]   s2_payload
);

   logic [fmul_pkg::prod_w-1:0] prod;
   logic [fmul_pkg::expi_w-1:0] exp_sum;

   assign prod    = {{fmul_pkg::mant_w{1'b0}}, s1_mant_a} * {{fmul_pkg::mant_w{1'b0}}, s1_mant_b};
   // bias removed once here, leading zeros come off in stage 3
   assign exp_sum = {{(fmul_pkg::expi_w-fmul_pkg::exp_w){1'b0}}, s1_exp_a}
                  + {{(fmul_pkg::expi_w-fmul_pkg::exp_w){1'b0}}, s1_exp_b}
                  - fmul_pkg::bias_adj;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s2_valid <= 1'b0;
      end else begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s2_sign    <= s1_sign;
      s2_prod    <= prod;
      s2_exp_sum <= exp_sum;
      s2_class   <= s1_class;
      s2_payload <= s1_payload;
   end

endmodule

`default_nettype wire

// ==== hdl/fmul_normalize.sv ====
`default_nettype none
`timescale 1ns/100ps

module fmul_normalize (
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        s2_valid,
   input  logic                                        s2_sign,
   input  logic [fmul_pkg::prod_w-1:0]                 s2_prod,
   input  logic [fmul_pkg::expi_w-1:0]                 s2_exp_sum,
   input  fmul_pkg::spec_t                             s2_class,
   input  logic [fmul_pkg::word_w-1:0]                 s2_payload,
   output logic                                        s3_valid,
   output logic                                        s3_sign,
   output logic [fmul_pkg::prod_w+fmul_pkg::frac_w-1:0] s3_mant,
   output logic [fmul_pkg::exp_w-1:0]                  s3_exp,
   output logic [fmul_pkg::exp_w-1:0]                  s3_exp_inc,
   output fmul_pkg::spec_t                             s3_class,
   output logic [fmul_pkg::word_w-1:0]                 s3_payload
);

   logic [fmul_pkg::expi_w-1:0]                 lz;
   logic [fmul_pkg::prod_w-1:0]                 prod_sh;
   logic [fmul_pkg::expi_w-1:0]                 exp_t;
   logic [fmul_pkg::expi_w-1:0]                 exp_t_inc;
   logic [fmul_pkg::expi_w-1:0]                 rshift;
   logic [fmul_pkg::prod_w+fmul_pkg::frac_w-1:0] mant_wide;
   logic [fmul_pkg::prod_w+fmul_pkg::frac_w-1:0] mant_al;

   // clamp the signed exponent into 0..exp_max
   function automatic logic [fmul_pkg::exp_w-1:0] sat_exp(
      input logic [fmul_pkg::expi_w-1:0] e
   );
      if (e[fmul_pkg::expi_w-1]) begin
         sat_exp = '0;
      end else if (|e[fmul_pkg::expi_w-2:fmul_pkg::exp_w]) begin
         sat_exp = fmul_pkg::exp_max;
      end else begin
         sat_exp = e[fmul_pkg::exp_w-1:0];
      end
   endfunction

   // highest set bit wins, zero product gives prod_w
   always_comb begin
      lz = fmul_pkg::expi_w'(fmul_pkg::prod_w);
      for (int i = 0; i < fmul_pkg::prod_w; i++) begin
         if (s2_prod[i]) begin
            lz = fmul_pkg::expi_w'(fmul_pkg::prod_w - 1 - i);
         end
      end
   end

   assign prod_sh   = s2_prod << lz;
   assign exp_t     = s2_exp_sum - lz;
   assign exp_t_inc = exp_t + 1'b1;
   assign rshift    = 1'b1 - exp_t;
   assign mant_wide = {prod_sh, {fmul_pkg::frac_w{1'b0}}};

   // underflow goes into subnormal range
   always_comb begin
      if (exp_t[fmul_pkg::expi_w-1]) begin
         mant_al = mant_wide >> rshift;
      end else if (exp_t == '0) begin
         mant_al = mant_wide >> 1;
      end else begin
         mant_al = mant_wide;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s3_valid <= 1'b0;
      end else begin
         s3_valid <= s2_valid;
      end
   end

   always_ff @(posedge clk) begin
      s3_sign    <= s2_sign;
      s3_mant    <= mant_al;
      s3_exp     <= sat_exp(exp_t);
      s3_exp_inc <= sat_exp(exp_t_inc);
      s3_class   <= s2_class;
      s3_payload <= s2_payload;
   end

endmodule

`default_nettype wire

// ==== hdl/fmul_pipe.sv ====
`default_nettype none
`timescale 1ns/100ps

module fmul_pipe (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   input  logic [fmul_pkg::word_w-1:0] a,
   input  logic [fmul_pkg::word_w-1:0] b,
   output logic                        out_valid,
   output logic [fmul_pkg::word_w-1:0] y,
   output logic                        ovf
);

   // stage 1 outputs
   logic                        s1_valid;
   logic                        s1_sign;
   logic [fmul_pkg::mant_w-1:0] s1_mant_a;
   logic [fmul_pkg::mant_w-1:0] s1_mant_b;
   logic [fmul_pkg::exp_w-1:0]  s1_exp_a;
   logic [fmul_pkg::exp_w-1:0]  s1_exp_b;
   fmul_pkg::spec_t             s1_class;
   logic [fmul_pkg::word_w-1:0] s1_payload;

   // stage 2 outputs
   logic                        s2_valid;
   logic                        s2_sign;
   logic [fmul_pkg::prod_w-1:0] s2_prod;
   logic [fmul_pkg::expi_w-1:0] s2_exp_sum;
   fmul_pkg::spec_t             s2_class;
   logic [fmul_pkg::word_w-1:0] s2_payload;

   // stage 3 outputs
   logic                                        s3_valid;
   logic                                        s3_sign;
   logic [fmul_pkg::prod_w+fmul_pkg::frac_w-1:0] s3_mant;
   logic [fmul_pkg::exp_w-1:0]                  s3_exp;
   logic [fmul_pkg::exp_w-1:0]                  s3_exp_inc;
   fmul_pkg::spec_t                             s3_class;
   logic [fmul_pkg::word_w-1:0]                 s3_payload;

   fmul_unpack fmul_unpack_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .in_valid   (in_valid),
      .a          (a),
      .b          (b),
      .s1_valid   (s1_valid),
      .s1_sign    (s1_sign),
      .s1_mant_a  (s1_mant_a),
      .s1_mant_b  (s1_mant_b),
      .s1_exp_a   (s1_exp_a),
      .s1_exp_b   (s1_exp_b),
      .s1_class   (s1_class),
      .s1_payload (s1_payload)
   );

   fmul_mant_mult fmul_mant_mult_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .s1_valid   (s1_valid),
      .s1_sign    (s1_sign),
      .s1_mant_a  (s1_mant_a),
      .s1_mant_b  (s1_mant_b),
      .s1_exp_a   (s1_exp_a),
      .s1_exp_b   (s1_exp_b),
      .s1_class   (s1_class),
      .s1_payload (s1_payload),
      .s2_valid   (s2_valid),
      .s2_sign    (s2_sign),
      .s2_prod    (s2_prod),
      .s2_exp_sum (s2_exp_sum),
      .s2_class   (s2_class),
      .s2_payload (s2_payload)
   );

   fmul_normalize fmul_normalize_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .s2_valid   (s2_valid),
      .s2_sign    (s2_sign),
      .s2_prod    (s2_prod),
      .s2_exp_sum (s2_exp_sum),
      .s2_class   (s2_class),
      .s2_payload (s2_payload),
      .s3_valid   (s3_valid),
      .s3_sign    (s3_sign),
      .s3_mant    (s3_mant),
      .s3_exp     (s3_exp),
      .s3_exp_inc (s3_exp_inc),
      .s3_class   (s3_class),
      .s3_payload (s3_payload)
   );

   fmul_round_pack fmul_round_pack_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .s3_valid   (s3_valid),
      .s3_sign    (s3_sign),
      .s3_mant    (s3_mant),
      .s3_exp     (s3_exp),
      .s3_exp_inc (s3_exp_inc),
      .s3_class   (s3_class),
      .s3_payload (s3_payload),
      .out_valid  (out_valid),
      .y          (y),
      .ovf        (ovf)
   );

endmodule

`default_nettype wire

// ==== hdl/fmul_pkg.sv ====
`default_nettype none

package fmul_pkg;

   // single precision word layout
   localparam int word_w = 32;
   localparam int exp_w  = 8;
   localparam int frac_w = 23;

   // mantissa with hidden bit, and the full product
   localparam int mant_w = 24;
   localparam int prod_w = 48;

   // signed internal exponent, room for under- and overflow
   localparam int expi_w = 10;

   localparam logic [exp_w-1:0] exp_max = 8'd255;

   // bias less one, the product's leading one sits a bit above the hidden bit
   localparam logic [expi_w-1:0] bias_adj = 10'd126;

   // clock cycles from in_valid to out_valid
   localparam int stage_count = 4;

   // result class, decided once in stage 1
   typedef enum logic [2:0] {
      spec_none     = 3'd0,
      spec_nan_b    = 3'd1,
      spec_nan_a    = 3'd2,
      spec_zero_inf = 3'd3,
      spec_inf      = 3'd4
   } spec_t;

endpackage

`default_nettype wire

// ==== hdl/fmul_round_pack.sv ====
`default_nettype none
`timescale 1ns/100ps

module fmul_round_pack (
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        s3_valid,
   input  logic                                        s3_sign,
   input  logic [fmul_pkg::prod_w+fmul_pkg::frac_w-1:0] s3_mant,
   input  logic [fmul_pkg::exp_w-1:0]                  s3_exp,
   input  logic [fmul_pkg::exp_w-1:0]                  s3_exp_inc,
   input  fmul_pkg::spec_t                             s3_class,
   input  logic [fmul_pkg::word_w-1:0]                 s3_payload,
   output logic                                        out_valid,
   output logic [fmul_pkg::word_w-1:0]                 y,
   output logic                                        ovf
);

   logic [fmul_pkg::mant_w-1:0] keep;
   logic                        rbit;
   logic [fmul_pkg::mant_w:0]   rnd;
   logic [fmul_pkg::exp_w-1:0]  exp_fin;
   logic                        ordinary;
   logic                        ovf_next;
   logic [fmul_pkg::word_w-1:0] y_next;

   assign keep = s3_mant[$bits(s3_mant)-1 -: fmul_pkg::mant_w];
   assign rbit = s3_mant[$bits(s3_mant)-1-fmul_pkg::mant_w];

   // half up on magnitude, only the first dropped bit counts
   assign rnd = {1'b0, keep} + {{fmul_pkg::mant_w{1'b0}}, rbit};

   always_comb begin
      if (rnd[fmul_pkg::mant_w]) begin
         exp_fin = s3_exp_inc;
      end else if (rnd[fmul_pkg::mant_w-1] && (s3_exp == '0)) begin
         // subnormal rounded up into normal range
         exp_fin = {{(fmul_pkg::exp_w-1){1'b0}}, 1'b1};
      end else if (rnd[fmul_pkg::mant_w-1:0] == '0) begin
         exp_fin = '0;
      end else begin
         exp_fin = s3_exp;
      end
   end

   assign ordinary = (s3_class == fmul_pkg::spec_none);
   assign ovf_next = s3_valid && ordinary && (exp_fin == fmul_pkg::exp_max);

   // a carry out leaves the low fraction bits at zero
   always_comb begin
      if (!ordinary) begin
         y_next = s3_payload;
      end else if (exp_fin == fmul_pkg::exp_max) begin
         y_next = {s3_sign, fmul_pkg::exp_max, {fmul_pkg::frac_w{1'b0}}};
      end else begin
         y_next = {s3_sign, exp_fin, rnd[fmul_pkg::frac_w-1:0]};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         ovf       <= 1'b0;
      end else begin
         out_valid <= s3_valid;
         ovf       <= ovf_next;
      end
   end

   always_ff @(posedge clk) begin
      y <= y_next;
   end

endmodule

`default_nettype wire

// ==== hdl/fmul_unpack.sv ====
`default_nettype none
`timescale 1ns/100ps

module fmul_unpack (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          in_valid,
   input  logic [fmul_pkg::word_w-1:0]   a,
   input  logic [fmul_pkg::word_w-1:0]   b,
   output logic                          s1_valid,
   output logic                          s1_sign,
   output logic [fmul_pkg::mant_w-1:0]   s1_mant_a,
   output logic [fmul_pkg::mant_w-1:0]   s1_mant_b,
   output logic [fmul_pkg::exp_w-1:0]    s1_exp_a,
   output logic [fmul_pkg::exp_w-1:0]    s1_exp_b,
   output fmul_pkg::spec_t               s1_class,
   output logic [fmul_pkg::word_w-1:0]   s1_payload
);

   logic [fmul_pkg::exp_w-1:0]  exp_a;
   logic [fmul_pkg::exp_w-1:0]  exp_b;
   logic [fmul_pkg::frac_w-1:0] frac_a;
   logic [fmul_pkg::frac_w-1:0] frac_b;
   logic                        sign;
   logic                        nan_a;
   logic                        nan_b;
   logic                        inf_a;
   logic                        inf_b;
   logic                        zero_a;
   logic                        zero_b;
   fmul_pkg::spec_t             cls;
   logic [fmul_pkg::word_w-1:0] special;

   assign exp_a  = a[fmul_pkg::word_w-2 -: fmul_pkg::exp_w];
   assign exp_b  = b[fmul_pkg::word_w-2 -: fmul_pkg::exp_w];
   assign frac_a = a[fmul_pkg::frac_w-1:0];
   assign frac_b = b[fmul_pkg::frac_w-1:0];
   assign sign   = a[fmul_pkg::word_w-1] ^ b[fmul_pkg::word_w-1];

   assign nan_a  = (exp_a == fmul_pkg::exp_max) && (frac_a != '0);
   assign nan_b  = (exp_b == fmul_pkg::exp_max) && (frac_b != '0);
   assign inf_a  = (exp_a == fmul_pkg::exp_max) && (frac_a == '0);
   assign inf_b  = (exp_b == fmul_pkg::exp_max) && (frac_b == '0);
   assign zero_a = (exp_a == '0) && (frac_a == '0);
   assign zero_b = (exp_b == '0) && (frac_b == '0);

   // b's NaN wins and NaNs come out quiet
   always_comb begin
      special = {sign, fmul_pkg::exp_max, {fmul_pkg::frac_w{1'b0}}};
      if (nan_b) begin
         cls     = fmul_pkg::spec_nan_b;
         special = {b[fmul_pkg::word_w-1], fmul_pkg::exp_max, 1'b1,
                    frac_b[fmul_pkg::frac_w-2:0]};
      end else if (nan_a) begin
         cls     = fmul_pkg::spec_nan_a;
         special = {a[fmul_pkg::word_w-1], fmul_pkg::exp_max, 1'b1,
                    frac_a[fmul_pkg::frac_w-2:0]};
      end else if ((inf_a && zero_b) || (inf_b && zero_a)) begin
         cls     = fmul_pkg::spec_zero_inf;
         special = {1'b1, fmul_pkg::exp_max, 1'b1, {(fmul_pkg::frac_w-1){1'b0}}};
      end else if (inf_a || inf_b) begin
         cls     = fmul_pkg::spec_inf;
      end else begin
         cls     = fmul_pkg::spec_none;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= in_valid;
      end
   end

   // subnormals get exponent 1 and no hidden bit
   always_ff @(posedge clk) begin
      s1_sign    <= sign;
      s1_mant_a  <= {|exp_a, frac_a};
      s1_mant_b  <= {|exp_b, frac_b};
      s1_exp_a   <= (exp_a == '0) ? {{(fmul_pkg::exp_w-1){1'b0}}, 1'b1} : exp_a;
      s1_exp_b   <= (exp_b == '0) ? {{(fmul_pkg::exp_w-1){1'b0}}, 1'b1} : exp_b;
      s1_class   <= cls;
      s1_payload <= special;
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the fmul pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
      --top-module tb_fmul -o tb_fmul_sim; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_fmul_sim +verilator+error+limit+1000)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
   exit 0
fi
exit 1

// ==== sim.f ====
hdl/fmul_pkg.sv
hdl/fmul_unpack.sv
hdl/fmul_mant_mult.sv
hdl/fmul_normalize.sv
hdl/fmul_round_pack.sv
hdl/fmul_pipe.sv
verif/fmul_properties.sv
verif/tb_fmul.sv

// ==== verif/fmul_properties.sv ====
`default_nettype none
`timescale 1ns/100ps

module fmul_properties (
   input logic                        clk,
   input logic                        rst_n,
   input logic                        in_valid,
   input logic                        out_valid,
   input logic [fmul_pkg::word_w-1:0] y,
   input logic                        ovf
);

   // one result per operand pair, a fixed latency later
   property valid_follows_input;
      @(posedge clk) disable iff (!rst_n)
         out_valid == $past(in_valid, fmul_pkg::stage_count);
   endproperty

   property ovf_needs_valid;
      @(posedge clk) ovf |-> out_valid;
   endproperty

   // overflow always saturates to an infinity
   property ovf_gives_inf;
      @(posedge clk) ovf |->
         (y[fmul_pkg::word_w-2 -: fmul_pkg::exp_w] == fmul_pkg::exp_max) &&
         (y[fmul_pkg::frac_w-1:0] == '0);
   endproperty

   property quiet_in_reset;
      @(posedge clk) !rst_n |-> (!out_valid && !ovf);
   endproperty

   valid_latency_a: assert property (valid_follows_input)
      else $error("out_valid is not in_valid delayed by the pipeline latency");

   ovf_valid_a: assert property (ovf_needs_valid)
      else $error("ovf is high while out_valid is low");

   ovf_inf_a: assert property (ovf_gives_inf)
      else $error("ovf is high but y is not an infinity");

   reset_a: assert property (quiet_in_reset)
      else $error("out_valid or ovf is high during reset");

endmodule

`default_nettype wire

// ==== verif/tb_fmul.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_fmul;

   localparam int reset_cycles = 4;
   localparam int n_random     = 200;
   localparam int n_directed   = 27;
   localparam int n_gapped     = 40;
   localparam int max_gap      = 3;
   localparam int n_burst      = 4;
   localparam int n_tests      = 7;
   // every op and gap, two resets, and a drain per test
   localparam int cycle_limit  = 2 * reset_cycles + n_random + n_directed
                               + n_gapped * (1 + max_gap) + n_burst
                               + n_tests * (fmul_pkg::stage_count + 4)
                               + fmul_pkg::stage_count + 50;

   logic        clk;
   logic        rst_n;
   logic        in_valid;
   logic [31:0] a;
   logic [31:0] b;
   logic        out_valid;
   logic [31:0] y;
   logic        ovf;

   // {ovf, y} per operand pair with the oldest first
   logic [32:0]                      expect_q[$];
   logic [fmul_pkg::stage_count-1:0] valid_pipe;

   int errors       = 0;
   int results      = 0;
   int tests_passed = 0;
   int tests_failed = 0;
   int cycles       = 0;
   int mark_errors  = 0;
   int mark_results = 0;

   fmul_pipe fmul_pipe_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .a         (a),
      .b         (b),
      .out_valid (out_valid),
      .y         (y),
      .ovf       (ovf)
   );

   bind fmul_pipe fmul_properties fmul_properties_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .out_valid (out_valid),
      .y         (y),
      .ovf       (ovf)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   // IEEE single product rounded half up on magnitude
   function automatic logic [32:0] model_mul(input logic [31:0] op_a, input logic [31:0] op_b);
      logic        sy;
      logic [7:0]  xa;
      logic [7:0]  xb;
      logic [22:0] fa;
      logic [22:0] fb;
      logic [47:0] p;
      logic [23:0] keep;
      logic [24:0] r;
      logic        rb;
      int          ea;
      int          eb;
      int          e;
      int          k;
      int          sh;
      xa = op_a[30:23];
      xb = op_b[30:23];
      fa = op_a[22:0];
      fb = op_b[22:0];
      sy = op_a[31] ^ op_b[31];
      if (xb == 8'hff && fb != '0) begin
         return {1'b0, op_b[31], 8'hff, 1'b1, fb[21:0]};
      end
      if (xa == 8'hff && fa != '0) begin
         return {1'b0, op_a[31], 8'hff, 1'b1, fa[21:0]};
      end
      if ((xa == 8'hff && op_b[30:0] == '0) || (xb == 8'hff && op_a[30:0] == '0)) begin
         return {1'b0, 1'b1, 8'hff, 1'b1, 22'd0};
      end
      if (xa == 8'hff || xb == 8'hff) begin
         return {1'b0, sy, 8'hff, 23'd0};
      end
      ea = (xa == 8'd0) ? 1 : int'(xa);
      eb = (xb == 8'd0) ? 1 : int'(xb);
      p  = {24'd0, xa != 8'd0, fa} * {24'd0, xb != 8'd0, fb};
      if (p == '0) begin
         return {1'b0, sy, 31'd0};
      end
      k = 0;
      for (int i = 0; i < 48; i++) begin
         if (p[i]) begin
            k = i;
         end
      end
      // biased exponent with the leading one as hidden bit
      e = k + ea + eb - 173;
      if (e >= 1) begin
         keep = (k >= 23) ? 24'(p >> (k - 23)) : 24'(p << (23 - k));
         rb   = (k >= 24) ? p[k - 24] : 1'b0;
         r    = {1'b0, keep} + 25'(rb);
         if (r[24]) begin
            e = e + 1;
         end
         if (e >= 255) begin
            return {1'b1, sy, 8'hff, 23'd0};
         end
         return {1'b0, sy, 8'(e), r[22:0]};
      end
      // subnormal result in units of 2**-149
      sh = 151 - ea - eb;
      if (sh > 48) begin
         keep = '0;
         rb   = 1'b0;
      end else begin
         keep = 24'(p >> sh);
         rb   = p[sh - 1];
      end
      r = {1'b0, keep} + 25'(rb);
      return {1'b0, sy, r[23] ? 8'd1 : 8'd0, r[22:0]};
   endfunction

   function automatic logic [31:0] rand_normal();
      return {1'($urandom), 8'(64 + $urandom_range(126)), 23'($urandom)};
   endfunction

   task automatic send(input logic [31:0] op_a, input logic [31:0] op_b);
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      a        = op_a;
      b        = op_b;
      expect_q.push_back(model_mul(op_a, op_b));
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
         in_valid = 1'b0;
         a        = $urandom;
         b        = $urandom;
      end
   endtask

   task automatic finish_test(input string name);
      idle(1);
      while (expect_q.size() != 0) begin
         @(posedge clk);
      end
      idle(2);
      if (errors == mark_errors) begin
         tests_passed++;
         $display("%s: %0d results, no errors", name, results - mark_results);
      end else begin
         tests_failed++;
         $display("%s: %0d results, %0d errors", name, results - mark_results,
                  errors - mark_errors);
      end
      mark_errors  = errors;
      mark_results = results;
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_pipe <= '0;
      end else begin
         valid_pipe <= {valid_pipe[fmul_pkg::stage_count-2:0], in_valid};
      end
   end

   // outputs settle well before the falling edge
   always @(negedge clk) begin : check_outputs
      logic [32:0] want;
      assert (out_valid == valid_pipe[fmul_pkg::stage_count-1]) else begin
         $display("Fail at %0d ns: out_valid expected %b, got %b", $time,
                  valid_pipe[fmul_pkg::stage_count-1], out_valid);
         errors++;
      end
      assert (out_valid || !ovf) else begin
         $display("Fail at %0d ns: ovf expected 0, got %b", $time, ovf);
         errors++;
      end
      if (out_valid) begin
         if (expect_q.size() == 0) begin
            $display("out_valid rose at %0d ns with no result outstanding", $time);
            errors++;
         end else begin
            want = expect_q.pop_front();
            results++;
            assert (y === want[31:0]) else begin
               $display("Fail at %0d ns: y expected %h, got %h", $time, want[31:0], y);
               errors++;
            end
            assert (ovf === want[32]) else begin
               $display("Fail at %0d ns: ovf expected %b, got %b", $time, want[32], ovf);
               errors++;
            end
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: run still going after %0d clock cycles", cycles);
         $display("Test FAILED");
         $finish;
      end
   end

   initial begin
      void'($urandom(32'hb3ee));
      rst_n    = 1'b0;
      in_valid = 1'b0;
      a        = '0;
      b        = '0;
      repeat (reset_cycles) @(posedge clk);
      #1 rst_n = 1'b1;

      repeat (n_random) send(rand_normal(), rand_normal());
      finish_test("normal products");

      send(32'h3fc00001, 32'h3fc00000);
      send(32'hbfc00001, 32'h3fc00000);
      // mantissas are factors of 2**47-1, so the round carries out
      send(32'h3fa1e58f, 32'h3fca6691);
      send(32'h3f800001, 32'h3f800001);
      finish_test("rounding");

      send(32'h00000001, 32'h3f800000);
      send(32'h00400000, 32'h40000000);
      send(32'h00400000, 32'h3f000000);
      send(32'h00000003, 32'h3f000000);
      send(32'h80000001, 32'h3f000000);
      send(32'h3f800001, 32'h007fffff);
      send(32'h1f800000, 32'h20000000);
      send(32'h1fc00000, 32'h20000000);
      send(32'h10000000, 32'h10000000);
      send(32'h00000001, 32'h80000001);
      finish_test("subnormals and underflow");

      send(32'h7f000000, 32'h7f000000);
      send(32'hff000000, 32'h7f000000);
      send(32'h7f7fffff, 32'h3f800001);
      send(32'h5f800000, 32'hdf800000);
      send(32'h7f7fffff, 32'h3f800000);
      finish_test("overflow");

      send(32'h7fa00001, 32'h3f800000);
      send(32'h3f800000, 32'hff800123);
      send(32'h7f800001, 32'hffa00002);
      send(32'h00000000, 32'h7f800000);
      send(32'hff800000, 32'h80000000);
      send(32'h7f800000, 32'hc0000000);
      send(32'hff800000, 32'hff800000);
      send(32'h7f800000, 32'h00000001);
      finish_test("special operands");

      for (int i = 0; i < n_gapped; i++) begin
         send($urandom, $urandom);
         idle($urandom_range(max_gap));
      end
      finish_test("random gaps");

      @(posedge clk);
      #1 rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1 rst_n = 1'b1;
      repeat (n_burst) send(rand_normal(), rand_normal());
      finish_test("burst after reset");

      $display("tests passed %0d, failed %0d, results %0d, errors %0d",
               tests_passed, tests_failed, results, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
